//--- src/align_defs.svh
`ifndef ALIGN_DEFS_SVH
`define ALIGN_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// Word and bank geometry
`define WIDTH      32  // Bits per data word.
`define NUMVBNK    8   // Banks.
`define BITVBNK    3
`define NUMVROW    768 // Virtual rows per bank.
`define BITVROW    10

////////////////////////////////////////////////////////////////////////////
// Physical row packing
`define NUMWRDS    3   // Words per physical row, not a power of two.
`define BITWRDS    2
`define NUMSROW    256 // Physical rows per bank.
`define BITSROW    8

`define SRAM_DELAY 2   // Cycles from sampled read to data.

`endif

//--- src/align_pkg.sv
`default_nettype none

`include "align_defs.svh"

package align_pkg;

  typedef logic [`WIDTH-1:0]           word_t;
  typedef logic [`BITVBNK-1:0]         bank_t;
  typedef logic [`BITVROW-1:0]         vrow_t;
  typedef logic [`BITSROW-1:0]         srow_t;
  typedef logic [`BITWRDS-1:0]         lane_t;
  typedef logic [`BITWRDS+`BITSROW-1:0] padr_t;  // Lane above physical row.

  // One physical row, used as a flat vector for the masked merge and as
  // word lanes for insertion and extraction.
  typedef union packed {
    logic [`NUMWRDS*`WIDTH-1:0] flat;
    word_t [`NUMWRDS-1:0]       wrd;
  } row_u;

  typedef struct packed {
    bank_t bnk;
    vrow_t adr;
    word_t bw;   // Bit write enables.
    word_t din;
  } wr_cmd_t;

  typedef struct packed {
    bank_t bnk;
    vrow_t adr;
  } rd_cmd_t;

  typedef struct packed {
    bank_t bnk;
    srow_t adr;
    row_u  bw;
    row_u  din;
  } mem_wr_t;

  typedef struct packed {
    bank_t bnk;
    srow_t adr;
  } mem_rd_t;

endpackage

`default_nettype wire

//--- src/addr_split.sv
`timescale 1ns/10ps
`default_nettype none

`include "align_defs.svh"

module addr_split (
  input  align_pkg::vrow_t vrow,
  output align_pkg::srow_t srow,
  output align_pkg::lane_t lane
);

  // Divisor held at the virtual row width so the arithmetic stays in one width.
  localparam align_pkg::vrow_t WRDS = align_pkg::vrow_t'(`NUMWRDS);

  align_pkg::vrow_t quo;
  align_pkg::vrow_t prod;

  ////////////////////////////////////////////////////////////////////////////
  // Constant division
  //
  // The divisor is a constant, so synthesis reduces the divide to a small
  // multiply and shift network. The remainder comes from the quotient
  // instead of a second divider.

  assign quo  = vrow / WRDS;
  assign prod = quo * WRDS;  // Largest multiple of WRDS not above vrow.

  // For an in-range row the quotient fits the physical row width and the
  // remainder is always below NUMWRDS.
  assign srow = align_pkg::srow_t'(quo);
  assign lane = align_pkg::lane_t'(vrow - prod);

endmodule

`default_nettype wire

//--- src/align_wr.sv
`timescale 1ns/10ps
`default_nettype none

`include "align_defs.svh"

module align_wr (
  input  logic               write,
  input  align_pkg::wr_cmd_t wr_cmd,
  output logic               mem_write,
  output align_pkg::mem_wr_t mem_wr
);

  align_pkg::srow_t wr_srow;
  align_pkg::lane_t wr_lane;

  addr_split wr_split (
    .vrow (wr_cmd.adr),
    .srow (wr_srow),
    .lane (wr_lane)
  );

  assign mem_write = write;

  ////////////////////////////////////////////////////////////////////////////
  // Lane placement

  always_comb begin
    mem_wr.bnk      = wr_cmd.bnk;
    mem_wr.adr      = wr_srow;
    mem_wr.bw.flat  = '0;  // Other lanes keep their stored bits.
    mem_wr.din.flat = '0;
    for (int i = 0; i < `NUMWRDS; i++) begin
      if (wr_lane == align_pkg::lane_t'(i)) begin
        mem_wr.bw.wrd[i]  = wr_cmd.bw;
        mem_wr.din.wrd[i] = wr_cmd.din;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/align_rd.sv
`timescale 1ns/10ps
`default_nettype none

`include "align_defs.svh"

module align_rd (
  input  logic               clk,
  input  logic               rst,
  input  logic               read,
  input  align_pkg::rd_cmd_t rd_cmd,
  output logic               mem_read,
  output align_pkg::mem_rd_t mem_rd,
  input  align_pkg::row_u    mem_rd_dout,
  output logic               rd_vld,
  output align_pkg::word_t   rd_dout,
  output align_pkg::padr_t   rd_padr
);

  localparam int DLY = `SRAM_DELAY;

  align_pkg::srow_t rd_srow;
  align_pkg::lane_t rd_lane;

  logic [DLY-1:0]                   vld_pipe;
  align_pkg::lane_t [DLY-1:0]       lane_pipe;
  align_pkg::padr_t [DLY-1:0]       padr_pipe;

  addr_split rd_split (
    .vrow (rd_cmd.adr),
    .srow (rd_srow),
    .lane (rd_lane)
  );

  // The physical read leaves in the same cycle as the command.
  assign mem_read   = read;
  assign mem_rd.bnk = rd_cmd.bnk;
  assign mem_rd.adr = rd_srow;

  ////////////////////////////////////////////////////////////////////////////
  // Side pipeline matching the SRAM latency

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe[0] <= read;
      for (int i = 1; i < DLY; i++) begin
        vld_pipe[i] <= vld_pipe[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    lane_pipe[0] <= rd_lane;
    padr_pipe[0] <= {rd_lane, rd_srow};
    for (int i = 1; i < DLY; i++) begin
      lane_pipe[i] <= lane_pipe[i-1];
      padr_pipe[i] <= padr_pipe[i-1];
    end
  end

  assign rd_vld  = vld_pipe[DLY-1];
  assign rd_padr = padr_pipe[DLY-1];

  always_comb begin
    rd_dout = '0;
    for (int i = 0; i < `NUMWRDS; i++) begin
      if (lane_pipe[DLY-1] == align_pkg::lane_t'(i)) begin
        rd_dout = mem_rd_dout.wrd[i];  // Lane returned with this read.
      end
    end
  end

endmodule

`default_nettype wire

//--- src/bank_sram.sv
`timescale 1ns/10ps
`default_nettype none

`include "align_defs.svh"

module bank_sram (
  input  logic               clk,
  input  logic               rst,
  input  logic               mem_write,
  input  align_pkg::mem_wr_t mem_wr,
  input  logic               mem_read,
  input  align_pkg::mem_rd_t mem_rd,
  output align_pkg::row_u    mem_rd_dout
);

  localparam int DLY = `SRAM_DELAY;

  align_pkg::row_u mem [`NUMVBNK][`NUMSROW];
  align_pkg::row_u rd_pipe [DLY];

  ////////////////////////////////////////////////////////////////////////////
  // Array write
  //
  // Masked merge over the whole row. Lanes with a zero mask are rewritten
  // with their old contents.

  always_ff @(posedge clk) begin
    if (mem_write) begin
      mem[mem_wr.bnk][mem_wr.adr].flat <=
        (mem_wr.din.flat & mem_wr.bw.flat) |
        (mem[mem_wr.bnk][mem_wr.adr].flat & ~mem_wr.bw.flat);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read pipeline

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DLY; i++) begin
        rd_pipe[i] <= '0;
      end
    end else begin
      if (mem_read) begin
        rd_pipe[0] <= mem[mem_rd.bnk][mem_rd.adr];  // Array read at the edge.
      end
      for (int i = 1; i < DLY; i++) begin
        rd_pipe[i] <= rd_pipe[i-1];
      end
    end
  end

  assign mem_rd_dout = rd_pipe[DLY-1];

endmodule

`default_nettype wire

//--- src/align_top.sv
`timescale 1ns/10ps
`default_nettype none

module align_top (
  input  logic               clk,
  input  logic               rst,
  input  logic               write,
  input  align_pkg::wr_cmd_t wr_cmd,
  input  logic               read,
  input  align_pkg::rd_cmd_t rd_cmd,
  output logic               rd_vld,
  output align_pkg::word_t   rd_dout,
  output align_pkg::padr_t   rd_padr
);

  logic               mem_write;
  align_pkg::mem_wr_t mem_wr;
  logic               mem_read;
  align_pkg::mem_rd_t mem_rd;
  align_pkg::row_u    mem_rd_dout;

  ////////////////////////////////////////////////////////////////////////////
  // Aligners

  align_wr u_wr (
    .write     (write),
    .wr_cmd    (wr_cmd),
    .mem_write (mem_write),
    .mem_wr    (mem_wr)
  );

  align_rd u_rd (
    .clk         (clk),
    .rst         (rst),
    .read        (read),
    .rd_cmd      (rd_cmd),
    .mem_read    (mem_read),
    .mem_rd      (mem_rd),
    .mem_rd_dout (mem_rd_dout),
    .rd_vld      (rd_vld),
    .rd_dout     (rd_dout),
    .rd_padr     (rd_padr)
  );

  // Both requests reach the banks in the same cycle on different banks.
  bank_sram u_sram (
    .clk         (clk),
    .rst         (rst),
    .mem_write   (mem_write),
    .mem_wr      (mem_wr),
    .mem_read    (mem_read),
    .mem_rd      (mem_rd),
    .mem_rd_dout (mem_rd_dout)
  );

endmodule

`default_nettype wire

//--- testbench/align_chk.sv
`timescale 1ns/10ps
`default_nettype none

`include "align_defs.svh"

module align_chk (
  input logic               clk,
  input logic               rst,
  input logic               write,
  input align_pkg::wr_cmd_t wr_cmd,
  input logic               read,
  input align_pkg::rd_cmd_t rd_cmd,
  input logic               rd_vld
);

  localparam int DLY = `SRAM_DELAY;

  int fail_cnt = 0;  // Failed assertions so far.

  ////////////////////////////////////////////////////////////////////////////
  // Address range and bank conflict

  a_wr_range: assert property (@(posedge clk) disable iff (rst)
    write |-> (wr_cmd.adr < `NUMVROW))
    else begin
      $error("write row out of range");
      fail_cnt++;
    end

  a_rd_range: assert property (@(posedge clk) disable iff (rst)
    read |-> (rd_cmd.adr < `NUMVROW))
    else begin
      $error("read row out of range");
      fail_cnt++;
    end

  a_bank_split: assert property (@(posedge clk) disable iff (rst)
    !(write && read && (wr_cmd.bnk == rd_cmd.bnk)))
    else begin
      $error("read and write to the same bank in one cycle");
      fail_cnt++;
    end

  ////////////////////////////////////////////////////////////////////////////
  // Read latency

  a_vld_follows: assert property (@(posedge clk) disable iff (rst)
    read |-> ##DLY rd_vld)
    else begin
      $error("rd_vld missing after read");
      fail_cnt++;
    end

  a_vld_caused: assert property (@(posedge clk) disable iff (rst)
    rd_vld |-> $past(read, DLY))
    else begin
      $error("rd_vld without a read");
      fail_cnt++;
    end

endmodule

bind align_top align_chk chk (
  .clk    (clk),
  .rst    (rst),
  .write  (write),
  .wr_cmd (wr_cmd),
  .read   (read),
  .rd_cmd (rd_cmd),
  .rd_vld (rd_vld)
);

`default_nettype wire

//--- testbench/align_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "align_defs.svh"

module align_tb;

  localparam int PERIOD   = 100;
  localparam int TBL_LEN  = 19;
  localparam int RAND_CYC = 200;

  typedef struct packed {
    logic               do_wr;
    align_pkg::wr_cmd_t wr;
    logic               do_rd;
    align_pkg::rd_cmd_t rd;
  } entry_t;

  typedef struct packed {
    align_pkg::word_t data;
    align_pkg::padr_t padr;
    logic [63:0]      due;  // Negedge time where rd_vld is expected.
  } want_t;

  logic               clk;
  logic               rst;
  logic               write;
  align_pkg::wr_cmd_t wr_cmd;
  logic               read;
  align_pkg::rd_cmd_t rd_cmd;
  logic               rd_vld;
  align_pkg::word_t   rd_dout;
  align_pkg::padr_t   rd_padr;

  align_pkg::word_t   shadow [`NUMVBNK][`NUMVROW];
  bit                 written [`NUMVBNK][`NUMVROW];
  align_pkg::rd_cmd_t pool [$];  // Locations that hold a full word.
  want_t              want_q [$];
  want_t              mon_want;
  int                 err_data = 0;
  int                 err_padr = 0;
  int                 err_proto = 0;

  // Each entry holds the write flag and command, then the read flag and command.
  localparam entry_t STIM [TBL_LEN] = '{
    '{1'b1, '{3'd0, 10'd5, 32'hFFFF_FFFF, 32'hDEAD_BEEF}, 1'b0, '{3'd0, 10'd0}},
    '{1'b0, '{3'd0, 10'd0, 32'h0, 32'h0}, 1'b1, '{3'd0, 10'd5}},
    '{1'b1, '{3'd0, 10'd5, 32'h0000_FFFF, 32'h1234_5678}, 1'b0, '{3'd0, 10'd0}},
    '{1'b0, '{3'd0, 10'd0, 32'h0, 32'h0}, 1'b1, '{3'd0, 10'd5}},
    '{1'b1, '{3'd2, 10'd30, 32'hFFFF_FFFF, 32'h1111_1111}, 1'b0, '{3'd0, 10'd0}},
    '{1'b1, '{3'd2, 10'd31, 32'hFFFF_FFFF, 32'h2222_2222}, 1'b0, '{3'd0, 10'd0}},
    '{1'b1, '{3'd2, 10'd32, 32'hFFFF_FFFF, 32'h3333_3333}, 1'b0, '{3'd0, 10'd0}},
    '{1'b1, '{3'd3, 10'd31, 32'hFFFF_FFFF, 32'h4444_4444}, 1'b1, '{3'd2, 10'd30}},
    '{1'b0, '{3'd0, 10'd0, 32'h0, 32'h0}, 1'b1, '{3'd2, 10'd31}},
    '{1'b0, '{3'd0, 10'd0, 32'h0, 32'h0}, 1'b1, '{3'd2, 10'd32}},
    '{1'b0, '{3'd0, 10'd0, 32'h0, 32'h0}, 1'b1, '{3'd3, 10'd31}},
    '{1'b1, '{3'd2, 10'd31, 32'hFF00_FF00, 32'hAABB_CCDD}, 1'b1, '{3'd3, 10'd31}},
    '{1'b0, '{3'd0, 10'd0, 32'h0, 32'h0}, 1'b1, '{3'd2, 10'd31}},
    '{1'b1, '{3'd7, 10'd765, 32'hFFFF_FFFF, 32'h7650_0765}, 1'b0, '{3'd0, 10'd0}},
    '{1'b1, '{3'd7, 10'd766, 32'hFFFF_FFFF, 32'h7660_0766}, 1'b0, '{3'd0, 10'd0}},
    '{1'b1, '{3'd7, 10'd767, 32'hFFFF_FFFF, 32'h7670_0767}, 1'b1, '{3'd2, 10'd30}},
    '{1'b0, '{3'd0, 10'd0, 32'h0, 32'h0}, 1'b1, '{3'd7, 10'd765}},
    '{1'b0, '{3'd0, 10'd0, 32'h0, 32'h0}, 1'b1, '{3'd7, 10'd766}},
    '{1'b0, '{3'd0, 10'd0, 32'h0, 32'h0}, 1'b1, '{3'd7, 10'd767}}
  };

  align_top UUT (
    .clk     (clk),
    .rst     (rst),
    .write   (write),
    .wr_cmd  (wr_cmd),
    .read    (read),
    .rd_cmd  (rd_cmd),
    .rd_vld  (rd_vld),
    .rd_dout (rd_dout),
    .rd_padr (rd_padr)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks and driver

  task automatic check_data(input align_pkg::word_t got, input align_pkg::word_t want);
    if (got !== want) begin
      $display("ERR %0t: rd_dout %h, expected %h", $time, got, want);
      err_data++;
    end
  endtask

  task automatic check_padr(input align_pkg::padr_t got, input align_pkg::padr_t want);
    if (got !== want) begin
      $display("ERR %0t: rd_padr %h, expected %h", $time, got, want);
      err_padr++;
    end
  endtask

  task automatic drive(input entry_t e);
    want_t              w;
    align_pkg::rd_cmd_t loc;
    @(posedge clk);
    write  <= e.do_wr;
    wr_cmd <= e.wr;
    read   <= e.do_rd;
    rd_cmd <= e.rd;
    if (e.do_rd) begin
      w.data = shadow[e.rd.bnk][e.rd.adr];
      w.padr = {align_pkg::lane_t'(e.rd.adr % `NUMWRDS),
                align_pkg::srow_t'(e.rd.adr / `NUMWRDS)};
      // Sampled one period from now, seen SRAM_DELAY edges after that.
      w.due  = $time + `SRAM_DELAY * PERIOD + PERIOD / 2;
      want_q.push_back(w);
    end
    if (e.do_wr) begin
      loc.bnk = e.wr.bnk;
      loc.adr = e.wr.adr;
      shadow[loc.bnk][loc.adr] = (e.wr.din & e.wr.bw) | (shadow[loc.bnk][loc.adr] & ~e.wr.bw);
      if (!written[loc.bnk][loc.adr] && e.wr.bw == '1) begin
        written[loc.bnk][loc.adr] = 1'b1;
        pool.push_back(loc);
      end
    end
  endtask

  // Outputs are stable at the falling edge.
  always @(negedge clk) begin
    if (!rst) begin
      if (rd_vld) begin
        if (want_q.size() == 0) begin
          $display("%0t: rd_vld high with no read outstanding", $time);
          err_proto++;
        end else begin
          mon_want = want_q.pop_front();
          if (mon_want.due != $time) begin
            $display("%0t: rd_vld expected at %0t", $time, mon_want.due);
            err_proto++;
          end
          check_data(rd_dout, mon_want.data);
          check_padr(rd_padr, mon_want.padr);
        end
      end else if (want_q.size() > 0 && want_q[0].due <= $time) begin
        $display("%0t: rd_vld missing for a read due at %0t", $time, want_q[0].due);
        mon_want = want_q.pop_front();
        err_proto++;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus

  initial begin
    entry_t e;
    void'($urandom(32'h9992));
    rst    = 1'b1;
    write  = 1'b0;
    wr_cmd = '0;
    read   = 1'b0;
    rd_cmd = '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < TBL_LEN; i++) begin
      drive(STIM[i]);
    end
    for (int n = 0; n < RAND_CYC; n++) begin
      e = '0;
      if (pool.size() > 0 && $urandom % 2 == 1) begin
        e.do_rd = 1'b1;
        e.rd    = pool[$urandom % pool.size()];
      end
      if ($urandom % 10 < 7) begin
        e.do_wr  = 1'b1;
        e.wr.bnk = e.do_rd ? align_pkg::bank_t'(e.rd.bnk + 1 + $urandom % 7)
                           : align_pkg::bank_t'($urandom);  // Never the read bank.
        e.wr.adr = align_pkg::vrow_t'(($urandom % 2) * 744 + $urandom % 24);
        e.wr.din = $urandom;
        e.wr.bw  = written[e.wr.bnk][e.wr.adr] ? $urandom : '1;
      end
      drive(e);
    end
    drive('0);
    while (want_q.size() > 0) @(negedge clk);
    @(negedge clk);
    $display("Errors: data %0d, padr %0d, protocol %0d, assertion %0d",
             err_data, err_padr, err_proto, UUT.chk.fail_cnt);
    if (err_data + err_padr + err_proto + UUT.chk.fail_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    #((TBL_LEN + RAND_CYC + 20) * PERIOD);
    $display("Timeout: the run did not finish in time");
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+src
src/align_pkg.sv
src/addr_split.sv
src/align_wr.sv
src/align_rd.sv
src/bank_sram.sv
src/align_top.sv
testbench/align_chk.sv
testbench/align_tb.sv

//--- Makefile
TOP := align_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): files.f src/*.sv src/*.svh testbench/*.sv
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f files.f

run: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Done: no errors'

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir
